/* include/core_params.svh */
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// Integer register and data bus width.
`define XLEN 64

// Doubleword index bits of the local data memory.
`define MEM_AW 8

// Delay stages between a request strobe and the array access. Must be 1 or more.
`define MEM_LATENCY 2

`endif

/* run_sim.sh */
#!/bin/sh
rm -f sim.log
verilator --binary --timing -Wno-fatal -f sim.f --top-module tb_mem_wb_top \
    -o tb_mem_wb_top > build.log 2>&1 && ./obj_dir/tb_mem_wb_top > sim.log 2>&1
cat sim.log 2>/dev/null || cat build.log
grep -q "STATUS: FAIL" sim.log && exit 1
grep -q "STATUS: PASS" sim.log || exit 1

/* sim.f */
+incdir+include
source/core_pkg.sv
source/lsu_if.sv
source/stage_if.sv
source/mem_stage.sv
source/data_mem.sv
source/mem_wb_reg.sv
source/wb_stage.sv
source/mem_wb_top.sv
sim/wb_checker.sv
sim/tb_mem_wb_top.sv

/* sim/tb_mem_wb_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module tb_mem_wb_top;
    import core_pkg::*;

    localparam int N_ALU       = 40;
    localparam int N_STORE     = 24;
    localparam int N_LOAD      = 24;
    localparam int N_BURST     = 8;     // Each memory access is chased by three others.
    localparam int N_CSR       = 20;
    localparam int N_MIX       = 400;
    localparam int N_TOTAL     = N_ALU + N_STORE + N_LOAD + 4 * N_BURST + N_CSR + N_MIX;
    localparam int CYCLE_LIMIT = 4 * N_TOTAL * (`MEM_LATENCY + 2);

    logic               clk;
    logic               rst;
    logic               in_valid;
    logic               in_ready;
    logic [31:0]        in_pc;
    logic [31:0]        in_inst;
    logic [4:0]         in_rd;
    logic               in_rd_w_en;
    wb_src_e            in_wb_src;
    mem_op_e            in_mem_op;
    logic [`XLEN-1:0]   in_exu_result;
    logic [`XLEN-1:0]   in_x_rs2;
    logic               in_csr_w_en;
    logic [11:0]        in_csr_addr;
    logic [`XLEN-1:0]   in_csr_r_data;
    logic               in_ebreak;
    logic               wb_valid;
    logic [31:0]        wb_pc;
    logic               wb_we;
    logic [4:0]         wb_rd;
    logic [`XLEN-1:0]   wb_data;
    logic               csr_we;
    logic [11:0]        csr_addr;
    logic [`XLEN-1:0]   csr_data;
    logic               ebreak;

    int errors;
    int accepts;
    int commits;
    int pending;
    int cycles = 0;
    int offered = 0;
    int err_mark = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    logic [31:0] lfsr;
    logic        counts_ok;

    // Port names match on both sides.
    mem_wb_top i_mem_wb_top (.*);
    wb_checker i_wb_checker (.*);

    always #4 clk = ~clk;

    always @(posedge clk) cycles <= cycles + 1;

    // Taps 32, 22, 2 and 1.
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v = {v[62:0], lfsr[0]};
        end
        return v;
    endfunction

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    task automatic fill_common();
        in_pc         = in_pc + 32'd4;
        in_inst       = 32'(rand_bits(32));
        in_rd         = 5'(rand_bits(5));
        in_rd_w_en    = 1'(rand_bits(1));
        in_x_rs2      = rand_bits(64);
        in_csr_addr   = 12'(rand_bits(12));
        in_csr_r_data = rand_bits(64);
    endtask

    task automatic wait_accept();
        in_valid = 1'b1;
        while (!in_ready) @(negedge clk);  // Fields stay put while stalled.
        offered++;
    endtask

    task automatic send_alu(input logic csr_heavy);
        @(negedge clk);
        fill_common();
        in_mem_op     = MEM_NONE;
        in_wb_src     = (rand_bits(1) != 0) ? WB_CSR : WB_EXU;
        in_exu_result = rand_bits(64);
        in_csr_w_en   = csr_heavy | (in_wb_src == WB_CSR && rand_bits(1) != 0);
        in_ebreak     = csr_heavy ? 1'(rand_bits(1)) : (rand_bits(3) == 0);
        wait_accept();
    endtask

    task automatic send_mem(input logic store, input int dw_bits);
        logic [2:0]  sel;
        logic [2:0]  off;
        logic [63:0] dw;
        @(negedge clk);
        fill_common();
        sel = 3'(rand_bits(3));
        if (store) begin
            in_mem_op = mem_op_e'(4'd8 + {2'b00, sel[1:0]});
        end else begin
            in_mem_op = (sel == 3'd7) ? LD : mem_op_e'({1'b0, sel} + 4'd1);
        end
        off = 3'(rand_bits(3));
        case (in_mem_op)
            SH, LH, LHU: off[0] = 1'b0;     // Natural alignment only.
            SW, LW, LWU: off[1:0] = 2'b00;
            SD, LD:      off = 3'b000;
            default:     ;
        endcase
        dw            = rand_bits(dw_bits);
        in_exu_result = {dw[60:0], off};
        in_wb_src     = store ? WB_EXU : WB_MEM;
        in_csr_w_en   = 1'b0;
        in_ebreak     = 1'b0;
        wait_accept();
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            in_valid = 1'b0;
        end
    endtask

    task automatic end_test(input string name);
        idle(1);
        while (pending != 0) @(negedge clk);
        if (errors == err_mark) begin
            tests_passed++;
            $display("PASS %s", name);
        end else begin
            tests_failed++;
            $display("FAIL %s with %0d mismatches", name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        clk           = 1'b0;
        rst           = 1'b1;
        in_valid      = 1'b0;
        in_pc         = 32'h0000_1000;
        in_inst       = '0;
        in_rd         = '0;
        in_rd_w_en    = 1'b0;
        in_wb_src     = WB_EXU;
        in_mem_op     = MEM_NONE;
        in_exu_result = '0;
        in_x_rs2      = '0;
        in_csr_w_en   = 1'b0;
        in_csr_addr   = '0;
        in_csr_r_data = '0;
        in_ebreak     = 1'b0;
        lfsr          = 32'h7fcb_29a2;
        repeat (4) @(negedge clk);
        rst = 1'b0;

        idle(6);
        end_test("reset state");
        repeat (N_ALU) send_alu(1'b0);
        end_test("non-memory commits");
        repeat (N_STORE) send_mem(1'b1, 2);
        repeat (N_LOAD) send_mem(1'b0, 2);
        end_test("stores and loads");
        repeat (N_BURST) begin
            send_mem(1'(rand_bits(1)), 2);
            repeat (3) send_alu(1'b0);
        end
        end_test("stall behind memory");
        repeat (N_CSR) send_alu(1'b1);
        end_test("csr and ebreak");
        for (int i = 0; i < N_MIX; i++) begin
            if (rand_bits(2) == 0) begin
                idle(1 + int'(rand_bits(2)));
            end
            case (rand_bits(2))
                0:       send_mem(1'b1, 4);
                1:       send_mem(1'b0, 4);
                default: send_alu(1'b0);
            endcase
        end
        end_test("random mix");

        counts_ok = (accepts == offered) && (commits == accepts);
        if (!counts_ok) begin
            $display("Counts disagree: %0d offered, %0d accepted, %0d committed",
                     offered, accepts, commits);
        end
        $display("Tests %0d passed, %0d failed; %0d accepted, %0d committed, %0d errors",
                 tests_passed, tests_failed, accepts, commits, errors);
        if (tests_failed == 0 && errors == 0 && counts_ok) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        while (cycles < CYCLE_LIMIT) @(negedge clk);
        $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* sim/wb_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module wb_checker (
    input  logic                clk,
    input  logic                rst,
    input  logic                in_valid,
    input  logic                in_ready,
    input  logic [31:0]         in_pc,
    input  logic [4:0]          in_rd,
    input  logic                in_rd_w_en,
    input  core_pkg::wb_src_e   in_wb_src,
    input  core_pkg::mem_op_e   in_mem_op,
    input  logic [`XLEN-1:0]    in_exu_result,
    input  logic [`XLEN-1:0]    in_x_rs2,
    input  logic                in_csr_w_en,
    input  logic [11:0]         in_csr_addr,
    input  logic [`XLEN-1:0]    in_csr_r_data,
    input  logic                in_ebreak,
    input  logic                wb_valid,
    input  logic [31:0]         wb_pc,
    input  logic                wb_we,
    input  logic [4:0]          wb_rd,
    input  logic [`XLEN-1:0]    wb_data,
    input  logic                csr_we,
    input  logic [11:0]         csr_addr,
    input  logic [`XLEN-1:0]    csr_data,
    input  logic                ebreak,
    output int                  errors,
    output int                  accepts,
    output int                  commits,
    output int                  pending
);
    import core_pkg::*;

    localparam int MEM_BYTES = 8 << `MEM_AW;

    typedef struct packed {
        logic [31:0] due;       // Cycle in which wb_valid must be high.
        logic [31:0] pc;
        logic        we;
        logic [4:0]  rd;
        logic [63:0] data;
        logic        csr_we;
        logic [11:0] csr_addr;
        logic [63:0] csr_data;
        logic        ebreak;
    } commit_t;

    commit_t    exp_q[$];
    logic [7:0] mem_model [MEM_BYTES];
    int         cyc = 0;
    int         ready_cyc = 0;

    initial begin
        errors  = 0;
        accepts = 0;
        commits = 0;
        pending = 0;
    end

    function automatic int access_bytes(mem_op_e op);
        case (op)
            LB, LBU, SB: return 1;
            LH, LHU, SH: return 2;
            LW, LWU, SW: return 4;
            LD, SD:      return 8;
            default:     return 0;
        endcase
    endfunction

    function automatic logic [63:0] load_value(mem_op_e op, logic [`MEM_AW+2:0] a);
        logic [63:0] v;
        int          n;
        n = access_bytes(op);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[i*8 +: 8] = mem_model[a + i];     // Little endian.
        end
        if ((op == LB || op == LH || op == LW) && v[n*8-1]) begin
            for (int i = n * 8; i < 64; i++) begin
                v[i] = 1'b1;
            end
        end
        return v;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%h, expected 0x%h at cycle %0d", name, got, exp, cyc);
            errors++;
        end
    endtask

    // ----------------------------------------
    // Model update and comparison
    // ----------------------------------------
    task automatic record_accept();
        commit_t             e;
        logic [`MEM_AW+2:0]  a;
        a          = in_exu_result[`MEM_AW+2:0];
        e.pc       = in_pc;
        e.rd       = in_rd;
        e.we       = in_rd_w_en && in_rd != 5'd0 && !(in_mem_op inside {SB, SH, SW, SD});
        e.csr_we   = in_csr_w_en;
        e.csr_addr = in_csr_addr;
        e.csr_data = in_exu_result;
        e.ebreak   = in_ebreak;
        case (in_wb_src)
            WB_MEM:  e.data = load_value(in_mem_op, a);
            WB_CSR:  e.data = in_csr_r_data;
            default: e.data = in_exu_result;
        endcase
        if (in_mem_op inside {SB, SH, SW, SD}) begin
            for (int i = 0; i < access_bytes(in_mem_op); i++) begin
                mem_model[a + i] = in_x_rs2[i*8 +: 8];
            end
        end
        if (in_mem_op == MEM_NONE) begin
            e.due = cyc + 1;
        end else begin
            e.due     = cyc + 1 + `MEM_LATENCY;
            ready_cyc = cyc + 1 + `MEM_LATENCY;
        end
        exp_q.push_back(e);
        accepts++;
    endtask

    task automatic check_commit();
        commit_t e;
        commits++;
        if (exp_q.size() == 0) begin
            $display("Commit of pc 0x%h arrived with nothing outstanding", wb_pc);
            errors++;
        end else begin
            e = exp_q.pop_front();
            if (cyc != int'(e.due)) begin
                $display("Commit of pc 0x%h came in cycle %0d instead of %0d",
                         e.pc, cyc, e.due);
                errors++;
            end
            check_value("wb_pc", wb_pc, e.pc);
            check_value("wb_we", wb_we, e.we);
            check_value("wb_rd", wb_rd, e.rd);
            check_value("wb_data", wb_data, e.data);
            check_value("csr_we", csr_we, e.csr_we);
            check_value("ebreak", ebreak, e.ebreak);
            if (e.csr_we) begin
                check_value("csr_addr", csr_addr, e.csr_addr);
                check_value("csr_data", csr_data, e.csr_data);
            end
        end
    endtask

    task automatic check_quiet();
        check_value("wb_we", wb_we, 0);
        check_value("csr_we", csr_we, 0);
        check_value("ebreak", ebreak, 0);
        if (exp_q.size() != 0 && cyc >= int'(exp_q[0].due)) begin
            $display("Commit of pc 0x%h did not arrive by cycle %0d", exp_q[0].pc, cyc);
            errors++;
            void'(exp_q.pop_front());
        end
    endtask

    always @(posedge clk) begin
        cyc = cyc + 1;
        if (rst) begin
            exp_q.delete();
            ready_cyc = 0;
            for (int i = 0; i < MEM_BYTES; i++) begin
                mem_model[i] = 8'h00;
            end
        end else begin
            check_value("in_ready", in_ready, cyc >= ready_cyc);
            if (wb_valid) begin
                check_commit();
            end else begin
                check_quiet();
            end
            if (in_valid && in_ready) begin
                record_accept();    // Commits are always older than this acceptance.
            end
        end
        pending = exp_q.size();
    end

endmodule

`default_nettype wire

/* source/core_pkg.sv */
`default_nettype none

package core_pkg;

    // Source of the value written to rd.
    typedef enum logic [1:0] {
        WB_EXU,
        WB_MEM,
        WB_CSR
    } wb_src_e;

    // Load and store opcodes, sized by access width.
    typedef enum logic [3:0] {
        MEM_NONE,
        LB, LH, LW, LD,
        LBU, LHU, LWU,
        SB, SH, SW, SD
    } mem_op_e;

    typedef enum logic {
        ACC_IDLE,
        ACC_BUSY
    } acc_state_e;

    function automatic logic mem_is_load(mem_op_e op);
        return (op >= LB) && (op <= LWU);
    endfunction

    function automatic logic mem_is_store(mem_op_e op);
        return (op >= SB) && (op <= SD);
    endfunction

endpackage

`default_nettype wire

/* source/data_mem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module data_mem (
    input  logic    clk,
    input  logic    rst,
    lsu_if.mem      lsu
);

    localparam int DEPTH = 1 << `MEM_AW;
    localparam int LAT   = `MEM_LATENCY;

    logic [`XLEN-1:0]   mem [DEPTH];
    logic [LAT-1:0]     pipe_rd;
    logic [LAT-1:0]     pipe_wr;
    logic [`MEM_AW-1:0] pipe_idx  [LAT];
    logic [`XLEN-1:0]   pipe_data [LAT];
    logic [7:0]         pipe_strb [LAT];
    logic [`MEM_AW-1:0] last_idx;

    assign last_idx = pipe_idx[LAT-1];

    // ----------------------------------------
    // Request delay line
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            pipe_rd <= '0;
            pipe_wr <= '0;
        end else begin
            pipe_rd[0] <= lsu.r_ready;
            pipe_wr[0] <= lsu.w_valid;
            for (int i = 1; i < LAT; i++) begin
                pipe_rd[i] <= pipe_rd[i-1];
                pipe_wr[i] <= pipe_wr[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        pipe_idx[0]  <= lsu.addr[`MEM_AW+2:3];  // Doubleword index.
        pipe_data[0] <= lsu.w_data;
        pipe_strb[0] <= lsu.w_strb;
        for (int i = 1; i < LAT; i++) begin
            pipe_idx[i]  <= pipe_idx[i-1];
            pipe_data[i] <= pipe_data[i-1];
            pipe_strb[i] <= pipe_strb[i-1];
        end
    end

    // ----------------------------------------
    // Array access and completion pulses
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
            lsu.r_valid <= 1'b0;
            lsu.w_ready <= 1'b0;
        end else begin
            lsu.r_valid <= pipe_rd[LAT-1];
            lsu.w_ready <= pipe_wr[LAT-1];
            if (pipe_wr[LAT-1]) begin
                for (int b = 0; b < 8; b++) begin
                    if (pipe_strb[LAT-1][b]) begin
                        mem[last_idx][b*8 +: 8] <= pipe_data[LAT-1][b*8 +: 8];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pipe_rd[LAT-1]) begin
            lsu.r_data <= mem[last_idx];    // The lane is picked later from the whole doubleword.
        end
    end

endmodule

`default_nettype wire

/* source/lsu_if.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

interface lsu_if;

    logic               r_ready;    // Read request strobe.
    logic               w_valid;    // Write request strobe.
    logic [`XLEN-1:0]   addr;       // Byte address.
    logic [`XLEN-1:0]   w_data;
    logic [7:0]         w_strb;
    logic               r_valid;    // Read completion pulse.
    logic               w_ready;    // Write completion pulse.
    logic [`XLEN-1:0]   r_data;

    modport core (
        output r_ready, w_valid, addr, w_data, w_strb,
        input  r_valid, w_ready
    );

    modport mem (
        input  r_ready, w_valid, addr, w_data, w_strb,
        output r_valid, w_ready, r_data
    );

    modport mon (
        input  r_ready, w_valid, r_valid, w_ready, r_data
    );

endinterface

`default_nettype wire

/* source/mem_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module mem_stage (
    input  logic                clk,
    input  logic                rst,
    input  logic                in_valid,
    output logic                in_ready,
    input  logic [31:0]         in_pc,
    input  logic [31:0]         in_inst,
    input  logic [4:0]          in_rd,
    input  logic                in_rd_w_en,
    input  core_pkg::wb_src_e   in_wb_src,
    input  core_pkg::mem_op_e   in_mem_op,
    input  logic [`XLEN-1:0]    in_exu_result,
    input  logic [`XLEN-1:0]    in_x_rs2,
    input  logic                in_csr_w_en,
    input  logic [11:0]         in_csr_addr,
    input  logic [`XLEN-1:0]    in_csr_r_data,
    input  logic                in_ebreak,
    lsu_if.core                 lsu,
    stage_if.src                stage
);
    import core_pkg::*;

    logic       accept;
    logic       issue;
    logic       busy;
    logic       done;
    logic [2:0] offset;

    assign in_ready = stage.ready;
    assign accept   = in_valid & stage.ready;
    assign done     = lsu.r_valid | lsu.w_ready;
    assign issue    = accept & (~busy | done);  // One access outstanding at most.
    assign offset   = in_exu_result[2:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (issue && in_mem_op != MEM_NONE) begin
            busy <= 1'b1;
        end else if (done) begin
            busy <= 1'b0;
        end
    end

    // ----------------------------------------
    // Request side
    // ----------------------------------------
    assign lsu.r_ready = issue & mem_is_load(in_mem_op);
    assign lsu.w_valid = issue & mem_is_store(in_mem_op);
    assign lsu.addr    = in_exu_result;
    assign lsu.w_data  = in_x_rs2 << {offset, 3'b000};  // Move store data into its byte lanes.

    always_comb begin
        case (in_mem_op)
            SB:      lsu.w_strb = 8'b0000_0001 << offset;
            SH:      lsu.w_strb = 8'b0000_0011 << offset;
            SW:      lsu.w_strb = 8'b0000_1111 << offset;
            SD:      lsu.w_strb = 8'b1111_1111;
            default: lsu.w_strb = 8'b0000_0000;
        endcase
    end

    // The instruction itself moves on to the pipeline register.
    assign stage.valid      = in_valid;
    assign stage.pc         = in_pc;
    assign stage.inst       = in_inst;
    assign stage.rd         = in_rd;
    assign stage.rd_w_en    = in_rd_w_en;
    assign stage.wb_src     = in_wb_src;
    assign stage.mem_op     = in_mem_op;
    assign stage.exu_result = in_exu_result;
    assign stage.csr_w_en   = in_csr_w_en;
    assign stage.csr_addr   = in_csr_addr;
    assign stage.csr_r_data = in_csr_r_data;
    assign stage.ebreak     = in_ebreak;

endmodule

`default_nettype wire

/* source/mem_wb_reg.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module mem_wb_reg (
    input  logic                clk,
    input  logic                rst,
    stage_if.dst                stage,
    lsu_if.mon                  lsu,
    output logic                out_valid,
    output logic [31:0]         out_pc,
    output logic [31:0]         out_inst,
    output logic [4:0]          out_rd,
    output logic                out_rd_w_en,
    output core_pkg::wb_src_e   out_wb_src,
    output core_pkg::mem_op_e   out_mem_op,
    output logic [`XLEN-1:0]    out_exu_result,
    output logic                out_csr_w_en,
    output logic [11:0]         out_csr_addr,
    output logic [`XLEN-1:0]    out_csr_r_data,
    output logic                out_ebreak,
    output logic [`XLEN-1:0]    out_lsu_r_data
);
    import core_pkg::*;

    acc_state_e state;
    logic       req;
    logic       done;
    logic       idle;
    logic       wen;
    logic       ctrl_flush;
    logic       out_valid_r;

    assign req  = lsu.r_ready | lsu.w_valid;
    assign done = lsu.r_valid | lsu.w_ready;
    assign idle = (state == ACC_IDLE) | done;   // Memory frees up in its completion cycle.

    assign stage.ready = idle;
    assign wen         = stage.valid & idle;
    assign ctrl_flush  = rst | (~stage.valid & out_valid);

    // While an access is open the held instruction retires on the completion pulse.
    assign out_valid      = (state == ACC_IDLE) ? out_valid_r : done;
    assign out_lsu_r_data = lsu.r_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ACC_IDLE;
        end else if (wen && req) begin
            state <= ACC_BUSY;
        end else if (done) begin
            state <= ACC_IDLE;
        end
    end

    // ----------------------------------------
    // Control fields
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (ctrl_flush) begin
            out_valid_r  <= 1'b0;
            out_rd_w_en  <= 1'b0;
            out_csr_w_en <= 1'b0;
            out_ebreak   <= 1'b0;
        end else begin
            out_valid_r <= wen;
            if (wen) begin
                out_rd_w_en  <= stage.rd_w_en;
                out_csr_w_en <= stage.csr_w_en;
                out_ebreak   <= stage.ebreak;
            end
        end
    end

    // Payload is held for as long as the memory is busy.
    always_ff @(posedge clk) begin
        if (wen) begin
            out_pc         <= stage.pc;
            out_inst       <= stage.inst;
            out_rd         <= stage.rd;
            out_wb_src     <= stage.wb_src;
            out_mem_op     <= stage.mem_op;
            out_exu_result <= stage.exu_result;
            out_csr_addr   <= stage.csr_addr;
            out_csr_r_data <= stage.csr_r_data;
        end
    end

endmodule

`default_nettype wire

/* source/mem_wb_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module mem_wb_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                in_valid,
    output logic                in_ready,
    input  logic [31:0]         in_pc,
    input  logic [31:0]         in_inst,
    input  logic [4:0]          in_rd,
    input  logic                in_rd_w_en,
    input  core_pkg::wb_src_e   in_wb_src,
    input  core_pkg::mem_op_e   in_mem_op,
    input  logic [`XLEN-1:0]    in_exu_result,
    input  logic [`XLEN-1:0]    in_x_rs2,
    input  logic                in_csr_w_en,
    input  logic [11:0]         in_csr_addr,
    input  logic [`XLEN-1:0]    in_csr_r_data,
    input  logic                in_ebreak,
    output logic                wb_valid,
    output logic [31:0]         wb_pc,
    output logic                wb_we,
    output logic [4:0]          wb_rd,
    output logic [`XLEN-1:0]    wb_data,
    output logic                csr_we,
    output logic [11:0]         csr_addr,
    output logic [`XLEN-1:0]    csr_data,
    output logic                ebreak
);
    import core_pkg::*;

    logic               mwb_valid;
    logic [31:0]        mwb_pc;
    logic [4:0]         mwb_rd;
    logic               mwb_rd_w_en;
    wb_src_e            mwb_wb_src;
    mem_op_e            mwb_mem_op;
    logic [`XLEN-1:0]   mwb_exu_result;
    logic               mwb_csr_w_en;
    logic [11:0]        mwb_csr_addr;
    logic [`XLEN-1:0]   mwb_csr_r_data;
    logic               mwb_ebreak;
    logic [`XLEN-1:0]   mwb_lsu_r_data;

    lsu_if   lsu ();
    stage_if stage ();

    // Port names match the top level one to one.
    mem_stage i_mem_stage (.*);

    data_mem i_data_mem (
        .clk (clk),
        .rst (rst),
        .lsu (lsu)
    );

    mem_wb_reg i_mem_wb_reg (
        .clk            (clk),
        .rst            (rst),
        .stage          (stage),
        .lsu            (lsu),
        .out_valid      (mwb_valid),
        .out_pc         (mwb_pc),
        .out_inst       (),
        .out_rd         (mwb_rd),
        .out_rd_w_en    (mwb_rd_w_en),
        .out_wb_src     (mwb_wb_src),
        .out_mem_op     (mwb_mem_op),
        .out_exu_result (mwb_exu_result),
        .out_csr_w_en   (mwb_csr_w_en),
        .out_csr_addr   (mwb_csr_addr),
        .out_csr_r_data (mwb_csr_r_data),
        .out_ebreak     (mwb_ebreak),
        .out_lsu_r_data (mwb_lsu_r_data)
    );

    wb_stage i_wb_stage (.*);

endmodule

`default_nettype wire

/* source/stage_if.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

interface stage_if;
    import core_pkg::*;

    logic               valid;
    logic               ready;
    logic [31:0]        pc;
    logic [31:0]        inst;
    logic [4:0]         rd;
    logic               rd_w_en;
    wb_src_e            wb_src;
    mem_op_e            mem_op;
    logic [`XLEN-1:0]   exu_result;     // Also the byte address of a load or store.
    logic               csr_w_en;
    logic [11:0]        csr_addr;
    logic [`XLEN-1:0]   csr_r_data;
    logic               ebreak;

    modport src (
        output valid, pc, inst, rd, rd_w_en, wb_src, mem_op, exu_result,
        output csr_w_en, csr_addr, csr_r_data, ebreak,
        input  ready
    );

    modport dst (
        input  valid, pc, inst, rd, rd_w_en, wb_src, mem_op, exu_result,
        input  csr_w_en, csr_addr, csr_r_data, ebreak,
        output ready
    );

endinterface

`default_nettype wire

/* source/wb_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module wb_stage (
    input  logic                mwb_valid,
    input  logic [31:0]         mwb_pc,
    input  logic [4:0]          mwb_rd,
    input  logic                mwb_rd_w_en,
    input  core_pkg::wb_src_e   mwb_wb_src,
    input  core_pkg::mem_op_e   mwb_mem_op,
    input  logic [`XLEN-1:0]    mwb_exu_result,
    input  logic                mwb_csr_w_en,
    input  logic [11:0]         mwb_csr_addr,
    input  logic [`XLEN-1:0]    mwb_csr_r_data,
    input  logic                mwb_ebreak,
    input  logic [`XLEN-1:0]    mwb_lsu_r_data,
    output logic                wb_valid,
    output logic [31:0]         wb_pc,
    output logic                wb_we,
    output logic [4:0]          wb_rd,
    output logic [`XLEN-1:0]    wb_data,
    output logic                csr_we,
    output logic [11:0]         csr_addr,
    output logic [`XLEN-1:0]    csr_data,
    output logic                ebreak
);
    import core_pkg::*;

    logic [`XLEN-1:0] lane;
    logic [`XLEN-1:0] load_data;

    // Bring the addressed bytes down to bit 0.
    assign lane = mwb_lsu_r_data >> {mwb_exu_result[2:0], 3'b000};

    always_comb begin
        case (mwb_mem_op)
            LB:      load_data = {{(`XLEN-8){lane[7]}}, lane[7:0]};
            LH:      load_data = {{(`XLEN-16){lane[15]}}, lane[15:0]};
            LW:      load_data = {{(`XLEN-32){lane[31]}}, lane[31:0]};
            LBU:     load_data = {{(`XLEN-8){1'b0}}, lane[7:0]};
            LHU:     load_data = {{(`XLEN-16){1'b0}}, lane[15:0]};
            LWU:     load_data = {{(`XLEN-32){1'b0}}, lane[31:0]};
            default: load_data = lane;
        endcase
    end

    always_comb begin
        case (mwb_wb_src)
            WB_MEM:  wb_data = load_data;
            WB_CSR:  wb_data = mwb_csr_r_data; // Old CSR value goes to rd.
            default: wb_data = mwb_exu_result;
        endcase
    end

    assign wb_valid = mwb_valid;
    assign wb_pc    = mwb_pc;
    assign wb_rd    = mwb_rd;
    assign wb_we    = mwb_valid & mwb_rd_w_en & (mwb_rd != 5'd0) & ~mem_is_store(mwb_mem_op);
    assign csr_we   = mwb_valid & mwb_csr_w_en;
    assign csr_addr = mwb_csr_addr;
    assign csr_data = mwb_exu_result;   // New CSR value comes from the execute result.
    assign ebreak   = mwb_valid & mwb_ebreak;

endmodule

`default_nettype wire
